// File: hdl/icache_scm_settings.svh
// Size settings of the instruction cache data store, included by its packages and testbench
`ifndef ICACHE_SCM_SETTINGS_SVH
`define ICACHE_SCM_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Geometry of the register-file memory
// ---------------------------------------------------------------------------

// Word address bits
`define ICACHE_SCM_ADDR_WIDTH 5

// Bits per stored word
`define ICACHE_SCM_DATA_WIDTH 32

// Word count, always two to the power of the address width
`define ICACHE_SCM_NUM_WORDS (2 ** `ICACHE_SCM_ADDR_WIDTH)

`endif

// File: hdl/scm_mem_pkg.sv
// Memory types of the instruction cache data store, shared by every RTL block and the testbench
`include "icache_scm_settings.svh"

package scm_mem_pkg;

    // -----------------------------------------------------------------------
    // Addresses and data
    // -----------------------------------------------------------------------

    // Word address on any read or write port
    typedef logic [`ICACHE_SCM_ADDR_WIDTH-1:0] scm_addr_t;

    // One instruction word as stored in the array
    typedef logic [`ICACHE_SCM_DATA_WIDTH-1:0] scm_word_t;

    // -----------------------------------------------------------------------
    // Per-word vectors
    // -----------------------------------------------------------------------

    // One bit per word
    // Carries the registered write enables and the read selects
    typedef logic [`ICACHE_SCM_NUM_WORDS-1:0] scm_onehot_t;

endpackage

// File: hdl/scm_write_pkg.sv
// Write-side types of the instruction cache data store, used by the write controller and array
package scm_write_pkg;

    // -----------------------------------------------------------------------
    // Write source
    // -----------------------------------------------------------------------

    // Which write port supplies a word on its next update
    // Port B takes priority on a same-word collision
    typedef enum logic
    {
        // Sampled data of write port A
        WSRC_A = 1'b0,
        // Sampled data of write port B
        WSRC_B = 1'b1
    } scm_wsrc_e;

endpackage

// File: hdl/scm_write_ctrl.sv
// Write controller of the data store: decodes both write ports and stages data for the array
module scm_write_ctrl
(
    input  logic                                                   clk,
    input  logic                                                   reset_i,

    // Write port A
    input  logic                                                   we_a_i,
    input  scm_mem_pkg::scm_addr_t                                 waddr_a_i,
    input  scm_mem_pkg::scm_word_t                                 wdata_a_i,

    // Write port B
    input  logic                                                   we_b_i,
    input  scm_mem_pkg::scm_addr_t                                 waddr_b_i,
    input  scm_mem_pkg::scm_word_t                                 wdata_b_i,

    // Staged write towards the word array
    output scm_mem_pkg::scm_onehot_t                               wen_o,
    output scm_write_pkg::scm_wsrc_e [$bits(scm_mem_pkg::scm_onehot_t)-1:0] wsrc_o,
    output scm_mem_pkg::scm_word_t                                 wdata_a_o,
    output scm_mem_pkg::scm_word_t                                 wdata_b_o
);

    import scm_mem_pkg::*;
    import scm_write_pkg::*;

    // Combinational one-hot hits of each port
    scm_onehot_t hit_a;
    scm_onehot_t hit_b;

    // Registered write state, applied by the array one cycle later
    scm_onehot_t                          wen_q;
    scm_wsrc_e [$bits(scm_onehot_t)-1:0]  wsrc_q;
    scm_word_t                            wdata_a_q;
    scm_word_t                            wdata_b_q;

    // -----------------------------------------------------------------------
    // Write address decode
    // -----------------------------------------------------------------------

    always_comb
    begin : p_wad
        hit_a = '0;
        hit_b = '0;
        // Only an enabled port sets its bit
        if (we_a_i)
            hit_a[waddr_a_i] = 1'b1;
        if (we_b_i)
            hit_b[waddr_b_i] = 1'b1;
    end

    // Word enables, cleared on reset so nothing is pending
    always_ff @(posedge clk)
    begin : p_wen
        if (reset_i)
            wen_q <= '0;
        else
            wen_q <= hit_a | hit_b;
    end

    // Port B wins wherever it hits, covering the collision case
    always_ff @(posedge clk)
    begin : p_wsrc
        for (int i = 0; i < $bits(scm_onehot_t); i++)
        begin
            wsrc_q[i] <= hit_b[i] ? WSRC_B : WSRC_A;
        end
    end

    // -----------------------------------------------------------------------
    // Write data sampling
    // -----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin : p_wdata
        if (we_a_i)
            wdata_a_q <= wdata_a_i;
        if (we_b_i)
            wdata_b_q <= wdata_b_i;
    end

    assign wen_o     = wen_q;
    assign wsrc_o    = wsrc_q;
    assign wdata_a_o = wdata_a_q;
    assign wdata_b_o = wdata_b_q;

    // A staged enable must trace back to an address seen on a port
    for (genvar w = 0; w < $bits(scm_onehot_t); w++)
    begin : g_wen_chk
        a_wen_addressed : assert property (@(posedge clk) disable iff (reset_i)
            wen_o[w] |-> $past((we_a_i && (waddr_a_i == w)) ||
                               (we_b_i && (waddr_b_i == w))));
    end

endmodule

// File: hdl/scm_read_ctrl.sv
// Read controller of the data store: holds both read addresses and decodes them to word selects
module scm_read_ctrl
(
    input  logic                     clk,
    input  logic                     reset_i,

    // Read port A
    input  logic                     ren_a_i,
    input  scm_mem_pkg::scm_addr_t   raddr_a_i,

    // Read port B
    input  logic                     ren_b_i,
    input  scm_mem_pkg::scm_addr_t   raddr_b_i,

    // One-hot word selects towards the array
    output scm_mem_pkg::scm_onehot_t rsel_a_o,
    output scm_mem_pkg::scm_onehot_t rsel_b_o
);

    import scm_mem_pkg::*;

    // Registered read addresses
    scm_addr_t raddr_a_q;
    scm_addr_t raddr_b_q;

    // -----------------------------------------------------------------------
    // Read address registers
    // -----------------------------------------------------------------------

    // A held address keeps its word on the output
    always_ff @(posedge clk)
    begin : p_raddr_a
        if (reset_i)
            raddr_a_q <= '0;
        else if (ren_a_i)
            raddr_a_q <= raddr_a_i;
    end

    always_ff @(posedge clk)
    begin : p_raddr_b
        if (reset_i)
            raddr_b_q <= '0;
        else if (ren_b_i)
            raddr_b_q <= raddr_b_i;
    end

    // -----------------------------------------------------------------------
    // Read select decode
    // -----------------------------------------------------------------------

    always_comb
    begin : p_rad
        rsel_a_o = '0;
        rsel_b_o = '0;
        rsel_a_o[raddr_a_q] = 1'b1;
        rsel_b_o[raddr_b_q] = 1'b1;
    end

    // The array relies on exactly one selected word per port
    a_rsel_onehot : assert property (@(posedge clk) disable iff (reset_i)
        $onehot(rsel_a_o) && $onehot(rsel_b_o));

endmodule

// File: hdl/scm_word_array.sv
// Word storage of the data store: flip-flop words written from staged data, read by one-hot selects
module scm_word_array
(
    input  logic                                                   clk,

    // Staged write from the write controller
    input  scm_mem_pkg::scm_onehot_t                               wen_i,
    input  scm_write_pkg::scm_wsrc_e [$bits(scm_mem_pkg::scm_onehot_t)-1:0] wsrc_i,
    input  scm_mem_pkg::scm_word_t                                 wdata_a_i,
    input  scm_mem_pkg::scm_word_t                                 wdata_b_i,

    // Word selects from the read controller
    input  scm_mem_pkg::scm_onehot_t                               rsel_a_i,
    input  scm_mem_pkg::scm_onehot_t                               rsel_b_i,

    // Read data
    output scm_mem_pkg::scm_word_t                                 rdata_a_o,
    output scm_mem_pkg::scm_word_t                                 rdata_b_o
);

    import scm_mem_pkg::*;
    import scm_write_pkg::*;

    // Stored words
    scm_word_t mem_q [$bits(scm_onehot_t)];

    // -----------------------------------------------------------------------
    // Write operation
    // -----------------------------------------------------------------------

    // Each enabled word loads the data of its source port
    always_ff @(posedge clk)
    begin : p_write
        for (int i = 0; i < $bits(scm_onehot_t); i++)
        begin
            if (wen_i[i])
            begin
                if (wsrc_i[i] == WSRC_B)
                    mem_q[i] <= wdata_b_i;
                else
                    mem_q[i] <= wdata_a_i;
            end
        end
    end

    // -----------------------------------------------------------------------
    // Read operation
    // -----------------------------------------------------------------------

    // AND-OR mux over all words
    // With a one-hot select only the chosen word survives
    always_comb
    begin : p_read
        rdata_a_o = '0;
        rdata_b_o = '0;
        for (int i = 0; i < $bits(scm_onehot_t); i++)
        begin
            rdata_a_o = rdata_a_o | (mem_q[i] & {$bits(scm_word_t){rsel_a_i[i]}});
            rdata_b_o = rdata_b_o | (mem_q[i] & {$bits(scm_word_t){rsel_b_i[i]}});
        end
    end

endmodule

// File: hdl/icache_scm_top.sv
// Top level of the instruction cache data store: two read and two write ports over a flop array
module icache_scm_top
(
    input  logic                   clk,
    input  logic                   reset_i,

    // Read port A
    input  logic                   ren_a_i,
    input  scm_mem_pkg::scm_addr_t raddr_a_i,
    output scm_mem_pkg::scm_word_t rdata_a_o,

    // Read port B
    input  logic                   ren_b_i,
    input  scm_mem_pkg::scm_addr_t raddr_b_i,
    output scm_mem_pkg::scm_word_t rdata_b_o,

    // Write port A
    input  logic                   we_a_i,
    input  scm_mem_pkg::scm_addr_t waddr_a_i,
    input  scm_mem_pkg::scm_word_t wdata_a_i,

    // Write port B
    input  logic                   we_b_i,
    input  scm_mem_pkg::scm_addr_t waddr_b_i,
    input  scm_mem_pkg::scm_word_t wdata_b_i
);

    import scm_mem_pkg::*;
    import scm_write_pkg::*;

    // Staged write, one cycle behind the ports
    scm_onehot_t                          wen;
    scm_wsrc_e [$bits(scm_onehot_t)-1:0]  wsrc;
    scm_word_t                            wdata_a;
    scm_word_t                            wdata_b;

    // Read word selects
    scm_onehot_t rsel_a;
    scm_onehot_t rsel_b;

    // -----------------------------------------------------------------------
    // Write side
    // -----------------------------------------------------------------------

    scm_write_ctrl u_write_ctrl
    (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_a_i    (we_a_i),
        .waddr_a_i (waddr_a_i),
        .wdata_a_i (wdata_a_i),
        .we_b_i    (we_b_i),
        .waddr_b_i (waddr_b_i),
        .wdata_b_i (wdata_b_i),
        .wen_o     (wen),
        .wsrc_o    (wsrc),
        .wdata_a_o (wdata_a),
        .wdata_b_o (wdata_b)
    );

    // -----------------------------------------------------------------------
    // Read side and storage
    // -----------------------------------------------------------------------

    scm_read_ctrl u_read_ctrl
    (
        .clk       (clk),
        .reset_i   (reset_i),
        .ren_a_i   (ren_a_i),
        .raddr_a_i (raddr_a_i),
        .ren_b_i   (ren_b_i),
        .raddr_b_i (raddr_b_i),
        .rsel_a_o  (rsel_a),
        .rsel_b_o  (rsel_b)
    );

    scm_word_array u_word_array
    (
        .clk       (clk),
        .wen_i     (wen),
        .wsrc_i    (wsrc),
        .wdata_a_i (wdata_a),
        .wdata_b_i (wdata_b),
        .rsel_a_i  (rsel_a),
        .rsel_b_i  (rsel_b),
        .rdata_a_o (rdata_a_o),
        .rdata_b_o (rdata_b_o)
    );

endmodule

// File: verif/tb_icache_scm.sv
// Table-driven testbench of the instruction cache data store, run as the simulation top level
`include "icache_scm_settings.svh"

module tb_icache_scm;

    import scm_mem_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_SEED    = 27;
    localparam int NUM_DIRECTED = 36;
    localparam int NUM_RANDOM   = 200;
    // Two idle rows at the end let the last reads and writes come out
    localparam int NUM_ROWS     = NUM_DIRECTED + NUM_RANDOM + 2;

    // DUT ports
    logic      clk;
    logic      reset_i;
    logic      ren_a_i;
    scm_addr_t raddr_a_i;
    scm_word_t rdata_a_o;
    logic      ren_b_i;
    scm_addr_t raddr_b_i;
    scm_word_t rdata_b_o;
    logic      we_a_i;
    scm_addr_t waddr_a_i;
    scm_word_t wdata_a_i;
    logic      we_b_i;
    scm_addr_t waddr_b_i;
    scm_word_t wdata_b_i;

    // Stimulus columns, row r is driven during cycle r
    logic      tbl_we_a [NUM_ROWS];
    scm_addr_t tbl_wa_a [NUM_ROWS];
    scm_word_t tbl_wd_a [NUM_ROWS];
    logic      tbl_we_b [NUM_ROWS];
    scm_addr_t tbl_wa_b [NUM_ROWS];
    scm_word_t tbl_wd_b [NUM_ROWS];
    logic      tbl_re_a [NUM_ROWS];
    scm_addr_t tbl_ra_a [NUM_ROWS];
    logic      tbl_re_b [NUM_ROWS];
    scm_addr_t tbl_ra_b [NUM_ROWS];

    // Expected columns, observed in cycle r before row r is driven
    logic      tbl_chk_a [NUM_ROWS];
    scm_word_t tbl_exp_a [NUM_ROWS];
    scm_addr_t tbl_reg_a [NUM_ROWS];
    logic      tbl_chk_b [NUM_ROWS];
    scm_word_t tbl_exp_b [NUM_ROWS];
    scm_addr_t tbl_reg_b [NUM_ROWS];

    int          num_checks;

    icache_scm_top u_dut
    (
        .clk       (clk),
        .reset_i   (reset_i),
        .ren_a_i   (ren_a_i),
        .raddr_a_i (raddr_a_i),
        .rdata_a_o (rdata_a_o),
        .ren_b_i   (ren_b_i),
        .raddr_b_i (raddr_b_i),
        .rdata_b_o (rdata_b_o),
        .we_a_i    (we_a_i),
        .waddr_a_i (waddr_a_i),
        .wdata_a_i (wdata_a_i),
        .we_b_i    (we_b_i),
        .waddr_b_i (waddr_b_i),
        .wdata_b_i (wdata_b_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------------------

    task automatic set_row(input int r, input int we_a, input int wa_a, input scm_word_t wd_a,
                           input int we_b, input int wa_b, input scm_word_t wd_b,
                           input int re_a, input int ra_a, input int re_b, input int ra_b);
        tbl_we_a[r] = (we_a != 0);
        tbl_wa_a[r] = scm_addr_t'(wa_a);
        tbl_wd_a[r] = wd_a;
        tbl_we_b[r] = (we_b != 0);
        tbl_wa_b[r] = scm_addr_t'(wa_b);
        tbl_wd_b[r] = wd_b;
        tbl_re_a[r] = (re_a != 0);
        tbl_ra_a[r] = scm_addr_t'(ra_a);
        tbl_re_b[r] = (re_b != 0);
        tbl_ra_b[r] = scm_addr_t'(ra_b);
    endtask

    task automatic add_directed_rows();
        // Single writes through one port at a time
        set_row(0, 1, 3, 32'hA000_0003, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(1, 0, 0, 32'h0, 1, 7, 32'hB000_0007, 0, 0, 0, 0);
        set_row(2, 1, 12, 32'hA000_000C, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(3, 0, 0, 32'h0, 1, 20, 32'hB000_0014, 0, 0, 0, 0);
        // Read back on both ports, different words per port
        set_row(4, 0, 0, 32'h0, 0, 0, 32'h0, 1, 3, 1, 7);
        set_row(5, 0, 0, 32'h0, 0, 0, 32'h0, 1, 12, 1, 20);
        set_row(6, 0, 0, 32'h0, 0, 0, 32'h0, 1, 7, 1, 3);
        set_row(7, 0, 0, 32'h0, 0, 0, 32'h0, 1, 20, 1, 12);
        // Parallel writes to different words
        set_row(8, 1, 1, 32'hA000_0001, 1, 2, 32'hB000_0002, 0, 0, 0, 0);
        set_row(9, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(10, 0, 0, 32'h0, 0, 0, 32'h0, 1, 1, 1, 2);
        // Same-word collision, port B must win
        set_row(11, 1, 5, 32'hA000_0005, 1, 5, 32'hB000_0005, 0, 0, 0, 0);
        set_row(12, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(13, 0, 0, 32'h0, 0, 0, 32'h0, 1, 5, 1, 5);
        // Port A holds word 3 while it is rewritten
        set_row(14, 0, 0, 32'h0, 0, 0, 32'h0, 1, 3, 0, 0);
        set_row(15, 1, 3, 32'hC000_0003, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(16, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(17, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(18, 0, 0, 32'h0, 0, 0, 32'h0, 1, 1, 1, 12);
        set_row(19, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        // Fill every word, even ones from port A and odd ones from port B
        for (int k = 0; k < 16; k++)
        begin
            set_row(20 + k, 1, 2 * k, scm_word_t'(32'hD000_0000 + 2 * k),
                    1, 2 * k + 1, scm_word_t'(32'hE000_0000 + 2 * k + 1), 0, 0, 0, 0);
        end
    endtask

    task automatic add_random_rows();
        int wa;
        int wb;
        for (int r = NUM_DIRECTED; r < NUM_DIRECTED + NUM_RANDOM; r++)
        begin
            wa = int'($urandom() % `ICACHE_SCM_NUM_WORDS);
            // About one row in four aims both writes at one word
            if ($urandom() % 4 == 0)
                wb = wa;
            else
                wb = int'($urandom() % `ICACHE_SCM_NUM_WORDS);
            set_row(r, int'($urandom() % 2), wa, scm_word_t'($urandom()),
                    int'($urandom() % 2), wb, scm_word_t'($urandom()),
                    int'($urandom() % 4 != 0), int'($urandom() % `ICACHE_SCM_NUM_WORDS),
                    int'($urandom() % 4 != 0), int'($urandom() % `ICACHE_SCM_NUM_WORDS));
        end
        set_row(NUM_ROWS - 2, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
        set_row(NUM_ROWS - 1, 0, 0, 32'h0, 0, 0, 32'h0, 0, 0, 0, 0);
    endtask

    // Shadow memory model of the write and read rules
    task automatic compute_expected();
        scm_word_t shadow [`ICACHE_SCM_NUM_WORDS];
        bit        written [`ICACHE_SCM_NUM_WORDS];
        scm_addr_t reg_a;
        scm_addr_t reg_b;
        reg_a = '0;
        reg_b = '0;
        foreach (written[w])
            written[w] = 1'b0;
        for (int c = 0; c < NUM_ROWS; c++)
        begin
            // A write lands at the edge ending the cycle after it was taken
            if (c >= 2)
            begin
                if (tbl_we_a[c-2])
                begin
                    shadow[tbl_wa_a[c-2]]  = tbl_wd_a[c-2];
                    written[tbl_wa_a[c-2]] = 1'b1;
                end
                // Port B goes last so it wins a collision
                if (tbl_we_b[c-2])
                begin
                    shadow[tbl_wa_b[c-2]]  = tbl_wd_b[c-2];
                    written[tbl_wa_b[c-2]] = 1'b1;
                end
            end
            tbl_reg_a[c] = reg_a;
            tbl_chk_a[c] = written[reg_a];
            tbl_exp_a[c] = shadow[reg_a];
            tbl_reg_b[c] = reg_b;
            tbl_chk_b[c] = written[reg_b];
            tbl_exp_b[c] = shadow[reg_b];
            // Addresses register at the edge ending the row's cycle
            if (tbl_re_a[c])
                reg_a = tbl_ra_a[c];
            if (tbl_re_b[c])
                reg_b = tbl_ra_b[c];
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks and row application
    // ------------------------------------------------------------------------

    task automatic check_word(input string name, input int row, input scm_word_t got,
                              input scm_word_t exp);
        num_checks++;
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h in row %0d", name, got, exp, row);
            $display("TB FAILED");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_addr(input string name, input int row, input scm_addr_t got,
                              input scm_addr_t exp);
        if (got !== exp)
        begin
            $display("** Error: %s = 0x%h, expected 0x%h in row %0d", name, got, exp, row);
            $display("TB FAILED");
            $fatal(1, "read address mismatch");
        end
    endtask

    task automatic verify_cycle(input int c);
        check_addr("u_read_ctrl.raddr_a_q", c, u_dut.u_read_ctrl.raddr_a_q, tbl_reg_a[c]);
        check_addr("u_read_ctrl.raddr_b_q", c, u_dut.u_read_ctrl.raddr_b_q, tbl_reg_b[c]);
        // Words never written hold no known value
        if (tbl_chk_a[c])
            check_word("rdata_a_o", c, rdata_a_o, tbl_exp_a[c]);
        if (tbl_chk_b[c])
            check_word("rdata_b_o", c, rdata_b_o, tbl_exp_b[c]);
    endtask

    task automatic apply_row(input int r);
        we_a_i    = tbl_we_a[r];
        waddr_a_i = tbl_wa_a[r];
        wdata_a_i = tbl_wd_a[r];
        we_b_i    = tbl_we_b[r];
        waddr_b_i = tbl_wa_b[r];
        wdata_b_i = tbl_wd_b[r];
        ren_a_i   = tbl_re_a[r];
        raddr_a_i = tbl_ra_a[r];
        ren_b_i   = tbl_re_b[r];
        raddr_b_i = tbl_ra_b[r];
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial
    begin : main_seq
        void'($urandom(RAND_SEED));
        num_checks = 0;
        clk        = 1'b0;
        reset_i    = 1'b1;
        ren_a_i    = 1'b0;
        raddr_a_i  = '0;
        ren_b_i    = 1'b0;
        raddr_b_i  = '0;
        we_a_i     = 1'b0;
        waddr_a_i  = '0;
        wdata_a_i  = '0;
        we_b_i     = 1'b0;
        waddr_b_i  = '0;
        wdata_b_i  = '0;
        add_directed_rows();
        add_random_rows();
        compute_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        // Check what the earlier rows produced, then drive this row
        for (int c = 0; c < NUM_ROWS; c++)
        begin
            verify_cycle(c);
            apply_row(c);
            @(negedge clk);
        end
        if (num_checks > 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            $display("No read data was compared during the run");
            $display("TB FAILED");
            $fatal(1, "no checks ran");
        end
    end

    initial
    begin : watchdog
        repeat (RESET_CYCLES + NUM_ROWS + 20) @(posedge clk);
        $display("Timeout: the stimulus table did not finish in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: icache_scm.f
+incdir+hdl
hdl/scm_mem_pkg.sv
hdl/scm_write_pkg.sv
hdl/scm_write_ctrl.sv
hdl/scm_read_ctrl.sv
hdl/scm_word_array.sv
hdl/icache_scm_top.sv
verif/tb_icache_scm.sv

// File: Makefile
# Verilator build and run of the instruction cache data store testbench
# Any variable below can be overridden on the command line

VERILATOR   ?= verilator
TOP         ?= tb_icache_scm
FILELIST    ?= icache_scm.f
BUILD_DIR   ?= obj_dir
JOBS        ?= 4
VFLAGS      ?= --binary --timing --assert -j $(JOBS)
EXTRA_FLAGS ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables:"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) JOBS=$(JOBS)"
	@echo "  VFLAGS=$(VFLAGS) EXTRA_FLAGS=$(EXTRA_FLAGS)"

# The simulation exits with a failing status on any $$fatal
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
